//--- verilog/corebus_switch_pkg.sv
// Shared widths and types for the request switch.
// MASTERS must equal 2**TARGET_WIDTH because the target field indexes the masters directly.
package corebus_switch_pkg;

  //////////////////////////////////////////////////
  // Bus widths
  //////////////////////////////////////////////////

  localparam int MASTERS      = 4;
  localparam int TARGET_WIDTH = 2;
  localparam int ADDR_WIDTH   = 16;
  localparam int ID_WIDTH     = 4;
  // Beats minus one, only meaningful for writes
  localparam int LEN_WIDTH    = 4;
  localparam int DATA_WIDTH   = 32;
  localparam int CMD_WIDTH    = 2;

  //////////////////////////////////////////////////
  // Command encoding
  //////////////////////////////////////////////////

  typedef enum logic [CMD_WIDTH-1:0] {
    CMD_READ         = 2'd0,
    CMD_WRITE        = 2'd1,
    CMD_WRITE_NP     = 2'd2,
    // Goes to every master, no data beats follow
    CMD_BROADCAST    = 2'd3
  } command_type;

  //////////////////////////////////////////////////
  // Address word
  //////////////////////////////////////////////////

  // Target select sits in the top bits
  typedef struct packed {
    logic [TARGET_WIDTH-1:0]            target;
    logic [ADDR_WIDTH-TARGET_WIDTH-1:0] offset;
  } addr_split;

  typedef union packed {
    logic [ADDR_WIDTH-1:0] raw;
    addr_split             split;
  } request_addr;

endpackage

//--- verilog/request_fifo.sv
// Synchronous FIFO with valid/accept on both sides and no fall-through.
// A pushed entry shows at the output one edge later. Any DEPTH of 1 or more works.
`timescale 1ns/1ps

module request_fifo #(
  parameter int DEPTH = 2,
  parameter int WIDTH = 8
)(
  input  logic             i_clk,
  input  logic             i_rst_n,
  input  logic             i_push_valid,
  output logic             o_push_accept,
  input  logic [WIDTH-1:0] i_push_data,
  output logic             o_pop_valid,
  input  logic             i_pop_accept,
  output logic [WIDTH-1:0] o_pop_data
);

  localparam int PTR_WIDTH   = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int COUNT_WIDTH = $clog2(DEPTH + 1);

  logic [WIDTH-1:0]       mem [DEPTH];
  logic [PTR_WIDTH-1:0]   wr_ptr;
  logic [PTR_WIDTH-1:0]   rd_ptr;
  logic [COUNT_WIDTH-1:0] count;
  logic                   push;
  logic                   pop;

  //////////////////////////////////////////////////
  // Handshake
  //////////////////////////////////////////////////

  assign o_push_accept = (count != COUNT_WIDTH'(DEPTH));
  assign o_pop_valid   = (count != '0);
  assign o_pop_data    = mem[rd_ptr];

  assign push = i_push_valid && o_push_accept;
  assign pop  = o_pop_valid && i_pop_accept;

  //////////////////////////////////////////////////
  // Storage
  //////////////////////////////////////////////////

  always_ff @(posedge i_clk) begin
    if (push) begin
      mem[wr_ptr] <= i_push_data;
    end
  end

  // Pointers wrap at DEPTH, so non power of two depths are fine
  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      wr_ptr <= '0;
    end else if (push) begin
      if (wr_ptr == PTR_WIDTH'(DEPTH - 1)) begin
        wr_ptr <= '0;
      end else begin
        wr_ptr <= wr_ptr + 1'b1;
      end
    end
  end

  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      rd_ptr <= '0;
    end else if (pop) begin
      if (rd_ptr == PTR_WIDTH'(DEPTH - 1)) begin
        rd_ptr <= '0;
      end else begin
        rd_ptr <= rd_ptr + 1'b1;
      end
    end
  end

  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      count <= '0;
    end else begin
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  a_count_bound: assert property (
    @(posedge i_clk) disable iff (!i_rst_n)
    count <= COUNT_WIDTH'(DEPTH)
  ) else $error("request_fifo count %0d above depth %0d", count, DEPTH);

endmodule

//--- verilog/switch_control.sv
// Routes the slave queue heads into the master queues. Combinational apart from tracking flops.
// Write data follows the most recent write command; a new write waits for the last beat.
`timescale 1ns/1ps

module switch_control (
  input  logic                                     i_clk,
  input  logic                                     i_rst_n,
  input  logic                                     i_cmd_valid,
  input  corebus_switch_pkg::command_type          i_cmd_type,
  input  corebus_switch_pkg::request_addr          i_cmd_addr,
  input  logic [corebus_switch_pkg::LEN_WIDTH-1:0] i_cmd_len,
  output logic                                     o_cmd_pop,
  input  logic                                     i_data_valid,
  input  logic                                     i_data_last,
  output logic                                     o_data_pop,
  output logic [corebus_switch_pkg::MASTERS-1:0]   o_cmd_push,
  input  logic [corebus_switch_pkg::MASTERS-1:0]   i_cmd_space,
  output logic [corebus_switch_pkg::MASTERS-1:0]   o_data_push,
  input  logic [corebus_switch_pkg::MASTERS-1:0]   i_data_space
);

  logic                                     is_broadcast;
  logic                                     is_write;
  logic                                     cmd_go;
  logic [corebus_switch_pkg::MASTERS-1:0]   target_mask;
  logic [corebus_switch_pkg::MASTERS-1:0]   cmd_need;
  logic [corebus_switch_pkg::MASTERS-1:0]   cmd_done;
  logic [corebus_switch_pkg::MASTERS-1:0]   data_route;
  logic                                     data_pending;
  logic [corebus_switch_pkg::LEN_WIDTH-1:0] beats_left;

  //////////////////////////////////////////////////
  // Target decode
  //////////////////////////////////////////////////

  assign is_broadcast = (i_cmd_type == corebus_switch_pkg::CMD_BROADCAST);
  assign is_write     = (i_cmd_type == corebus_switch_pkg::CMD_WRITE) ||
                        (i_cmd_type == corebus_switch_pkg::CMD_WRITE_NP);

  always_comb begin
    for (int i = 0; i < corebus_switch_pkg::MASTERS; i++) begin
      target_mask[i] = is_broadcast ||
        (i_cmd_addr.split.target == corebus_switch_pkg::TARGET_WIDTH'(i));
    end
  end

  //////////////////////////////////////////////////
  // Command routing
  //////////////////////////////////////////////////

  // Hold a new write until the previous write has drained its beats
  assign cmd_go   = i_cmd_valid && !(is_write && data_pending);

  // Masters that already took a broadcast drop out of the push set
  assign cmd_need = target_mask & ~cmd_done;

  assign o_cmd_push = cmd_go ? cmd_need : '0;

  // Release once every remaining target has space this cycle
  assign o_cmd_pop  = cmd_go && ((cmd_need & ~i_cmd_space) == '0);

  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      cmd_done <= '0;
    end else if (o_cmd_pop) begin
      cmd_done <= '0;
    end else begin
      cmd_done <= cmd_done | (o_cmd_push & i_cmd_space);
    end
  end

  //////////////////////////////////////////////////
  // Write data steering
  //////////////////////////////////////////////////

  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      data_pending <= 1'b0;
      data_route   <= '0;
      beats_left   <= '0;
    end else if (o_cmd_pop && is_write) begin
      data_pending <= 1'b1;
      data_route   <= target_mask;
      beats_left   <= i_cmd_len;
    end else if (o_data_pop) begin
      beats_left <= beats_left - 1'b1;
      if (i_data_last) begin
        data_pending <= 1'b0;
      end
    end
  end

  assign o_data_push = (data_pending && i_data_valid) ? data_route : '0;
  assign o_data_pop  = |(o_data_push & i_data_space);

  //////////////////////////////////////////////////
  // Checks
  //////////////////////////////////////////////////

  a_data_push_onehot: assert property (
    @(posedge i_clk) disable iff (!i_rst_n)
    $onehot0(o_data_push)
  ) else $error("switch_control data push not one-hot: %b", o_data_push);

  a_no_data_when_idle: assert property (
    @(posedge i_clk) disable iff (!i_rst_n)
    !data_pending |-> (o_data_push == '0)
  ) else $error("switch_control data pushed with no write pending");

  a_cmd_push_onehot: assert property (
    @(posedge i_clk) disable iff (!i_rst_n)
    (i_cmd_valid && !is_broadcast) |-> $onehot0(o_cmd_push)
  ) else $error("switch_control command push not one-hot: %b", o_cmd_push);

  // Last flag must line up with the burst length of the write it follows
  a_last_on_final_beat: assert property (
    @(posedge i_clk) disable iff (!i_rst_n)
    o_data_pop |-> (i_data_last == (beats_left == '0))
  ) else $error("switch_control last flag mismatch, %0d beats left", beats_left);

endmodule

//--- verilog/request_switch_top.sv
// One slave port to four master ports. Each queue adds one cycle; no response path.
// Master port arrays are indexed by the target field of the address.
`timescale 1ns/1ps

module request_switch_top #(
  parameter int CMD_DEPTH  = 4,
  parameter int DATA_DEPTH = 8
)(
  input  logic                                                   i_clk,
  input  logic                                                   i_rst_n,
  // Slave command channel
  input  logic                                                   i_scmd_valid,
  input  corebus_switch_pkg::command_type                        i_scmd_type,
  input  logic [corebus_switch_pkg::ID_WIDTH-1:0]                i_scmd_id,
  input  logic [corebus_switch_pkg::ADDR_WIDTH-1:0]              i_scmd_addr,
  input  logic [corebus_switch_pkg::LEN_WIDTH-1:0]               i_scmd_len,
  output logic                                                   o_scmd_accept,
  // Slave data channel
  input  logic                                                   i_sdata_valid,
  input  logic [corebus_switch_pkg::DATA_WIDTH-1:0]              i_sdata,
  input  logic                                                   i_sdata_last,
  output logic                                                   o_sdata_accept,
  // Master command channels
  output logic [corebus_switch_pkg::MASTERS-1:0]                 o_mcmd_valid,
  output corebus_switch_pkg::command_type [corebus_switch_pkg::MASTERS-1:0] o_mcmd_type,
  output logic [corebus_switch_pkg::MASTERS-1:0][corebus_switch_pkg::ID_WIDTH-1:0]
                                                                 o_mcmd_id,
  output logic [corebus_switch_pkg::MASTERS-1:0][corebus_switch_pkg::ADDR_WIDTH-1:0]
                                                                 o_mcmd_addr,
  output logic [corebus_switch_pkg::MASTERS-1:0][corebus_switch_pkg::LEN_WIDTH-1:0]
                                                                 o_mcmd_len,
  input  logic [corebus_switch_pkg::MASTERS-1:0]                 i_mcmd_accept,
  // Master data channels
  output logic [corebus_switch_pkg::MASTERS-1:0]                 o_mdata_valid,
  output logic [corebus_switch_pkg::MASTERS-1:0][corebus_switch_pkg::DATA_WIDTH-1:0]
                                                                 o_mdata,
  output logic [corebus_switch_pkg::MASTERS-1:0]                 o_mdata_last,
  input  logic [corebus_switch_pkg::MASTERS-1:0]                 i_mdata_accept
);

  // Command word layout, low to high: len, addr, id, type
  localparam int ADDR_LSB  = corebus_switch_pkg::LEN_WIDTH;
  localparam int ID_LSB    = ADDR_LSB + corebus_switch_pkg::ADDR_WIDTH;
  localparam int TYPE_LSB  = ID_LSB + corebus_switch_pkg::ID_WIDTH;
  localparam int CMD_WORD  = TYPE_LSB + corebus_switch_pkg::CMD_WIDTH;
  // Data word is last flag above the beat
  localparam int DATA_WORD = corebus_switch_pkg::DATA_WIDTH + 1;

  logic [CMD_WORD-1:0]                         scmd_head;
  logic                                        scmd_head_valid;
  logic                                        scmd_pop;
  corebus_switch_pkg::request_addr             scmd_head_addr;
  logic [DATA_WORD-1:0]                        sdata_head;
  logic                                        sdata_head_valid;
  logic                                        sdata_pop;
  logic [corebus_switch_pkg::MASTERS-1:0]      cmd_push;
  logic [corebus_switch_pkg::MASTERS-1:0]      cmd_space;
  logic [corebus_switch_pkg::MASTERS-1:0]      data_push;
  logic [corebus_switch_pkg::MASTERS-1:0]      data_space;
  logic [corebus_switch_pkg::MASTERS-1:0][CMD_WORD-1:0]  mcmd_word;
  logic [corebus_switch_pkg::MASTERS-1:0][DATA_WORD-1:0] mdata_word;

  //////////////////////////////////////////////////
  // Slave queues
  //////////////////////////////////////////////////

  request_fifo #(
    .DEPTH (CMD_DEPTH),
    .WIDTH (CMD_WORD)
  ) u_scmd_fifo (
    .i_clk         (i_clk),
    .i_rst_n       (i_rst_n),
    .i_push_valid  (i_scmd_valid),
    .o_push_accept (o_scmd_accept),
    .i_push_data   ({i_scmd_type, i_scmd_id, i_scmd_addr, i_scmd_len}),
    .o_pop_valid   (scmd_head_valid),
    .i_pop_accept  (scmd_pop),
    .o_pop_data    (scmd_head)
  );

  request_fifo #(
    .DEPTH (DATA_DEPTH),
    .WIDTH (DATA_WORD)
  ) u_sdata_fifo (
    .i_clk         (i_clk),
    .i_rst_n       (i_rst_n),
    .i_push_valid  (i_sdata_valid),
    .o_push_accept (o_sdata_accept),
    .i_push_data   ({i_sdata_last, i_sdata}),
    .o_pop_valid   (sdata_head_valid),
    .i_pop_accept  (sdata_pop),
    .o_pop_data    (sdata_head)
  );

  assign scmd_head_addr.raw = scmd_head[ADDR_LSB +: corebus_switch_pkg::ADDR_WIDTH];

  //////////////////////////////////////////////////
  // Routing
  //////////////////////////////////////////////////

  switch_control u_control (
    .i_clk        (i_clk),
    .i_rst_n      (i_rst_n),
    .i_cmd_valid  (scmd_head_valid),
    .i_cmd_type   (corebus_switch_pkg::command_type'(
                     scmd_head[TYPE_LSB +: corebus_switch_pkg::CMD_WIDTH])),
    .i_cmd_addr   (scmd_head_addr),
    .i_cmd_len    (scmd_head[0 +: corebus_switch_pkg::LEN_WIDTH]),
    .o_cmd_pop    (scmd_pop),
    .i_data_valid (sdata_head_valid),
    .i_data_last  (sdata_head[corebus_switch_pkg::DATA_WIDTH]),
    .o_data_pop   (sdata_pop),
    .o_cmd_push   (cmd_push),
    .i_cmd_space  (cmd_space),
    .o_data_push  (data_push),
    .i_data_space (data_space)
  );

  //////////////////////////////////////////////////
  // Master queues
  //////////////////////////////////////////////////

  // Same head word goes to every queue, the push strobe picks the taker
  for (genvar i = 0; i < corebus_switch_pkg::MASTERS; i++) begin : g_master
    request_fifo #(
      .DEPTH (CMD_DEPTH),
      .WIDTH (CMD_WORD)
    ) u_mcmd_fifo (
      .i_clk         (i_clk),
      .i_rst_n       (i_rst_n),
      .i_push_valid  (cmd_push[i]),
      .o_push_accept (cmd_space[i]),
      .i_push_data   (scmd_head),
      .o_pop_valid   (o_mcmd_valid[i]),
      .i_pop_accept  (i_mcmd_accept[i]),
      .o_pop_data    (mcmd_word[i])
    );

    request_fifo #(
      .DEPTH (DATA_DEPTH),
      .WIDTH (DATA_WORD)
    ) u_mdata_fifo (
      .i_clk         (i_clk),
      .i_rst_n       (i_rst_n),
      .i_push_valid  (data_push[i]),
      .o_push_accept (data_space[i]),
      .i_push_data   (sdata_head),
      .o_pop_valid   (o_mdata_valid[i]),
      .i_pop_accept  (i_mdata_accept[i]),
      .o_pop_data    (mdata_word[i])
    );

    assign o_mcmd_type[i]  = corebus_switch_pkg::command_type'(
                               mcmd_word[i][TYPE_LSB +: corebus_switch_pkg::CMD_WIDTH]);
    assign o_mcmd_id[i]    = mcmd_word[i][ID_LSB +: corebus_switch_pkg::ID_WIDTH];
    assign o_mcmd_addr[i]  = mcmd_word[i][ADDR_LSB +: corebus_switch_pkg::ADDR_WIDTH];
    assign o_mcmd_len[i]   = mcmd_word[i][0 +: corebus_switch_pkg::LEN_WIDTH];
    assign o_mdata[i]      = mdata_word[i][0 +: corebus_switch_pkg::DATA_WIDTH];
    assign o_mdata_last[i] = mdata_word[i][corebus_switch_pkg::DATA_WIDTH];
  end

endmodule

//--- dv/request_switch_tb.sv
// Reads dv/request_switch_tests.txt from the project root. Six hex columns per test.
// Master accepts stall at random; every arrival is compared against per-master queues.
`timescale 1ns/1ps

module request_switch_tb;

  localparam int MASTERS   = corebus_switch_pkg::MASTERS;
  localparam int MAX_TESTS = 32;
  localparam int MAX_EXP   = 128;
  localparam int SEED      = 32'hd403d3d6;

  logic                                    i_clk;
  logic                                    i_rst_n;
  logic                                    i_scmd_valid;
  corebus_switch_pkg::command_type         i_scmd_type;
  logic [3:0]                              i_scmd_id;
  logic [15:0]                             i_scmd_addr;
  logic [3:0]                              i_scmd_len;
  logic                                    o_scmd_accept;
  logic                                    i_sdata_valid;
  logic [31:0]                             i_sdata;
  logic                                    i_sdata_last;
  logic                                    o_sdata_accept;
  logic [MASTERS-1:0]                      o_mcmd_valid;
  corebus_switch_pkg::command_type [MASTERS-1:0] o_mcmd_type;
  logic [MASTERS-1:0][3:0]                 o_mcmd_id;
  logic [MASTERS-1:0][15:0]                o_mcmd_addr;
  logic [MASTERS-1:0][3:0]                 o_mcmd_len;
  logic [MASTERS-1:0]                      i_mcmd_accept;
  logic [MASTERS-1:0]                      o_mdata_valid;
  logic [MASTERS-1:0][31:0]                o_mdata;
  logic [MASTERS-1:0]                      o_mdata_last;
  logic [MASTERS-1:0]                      i_mdata_accept;

  logic [31:0] test_mem [MAX_TESTS*6];
  int          num_tests;
  int          limit_ns = 0;
  int          tb_errors = 0;
  logic        running = 1'b0;

  // Expected arrivals per master with the command word as {type, id, addr, len}
  logic [25:0] exp_cmd  [MASTERS][MAX_EXP];
  logic [32:0] exp_data [MASTERS][MAX_EXP];
  int          cmd_tail  [MASTERS];
  int          data_tail [MASTERS];
  int          cmd_end   [MAX_TESTS][MASTERS];
  int          data_end  [MAX_TESTS][MASTERS];
  int          cmd_seen  [MASTERS];
  int          data_seen [MASTERS];
  int          mon_errors [MASTERS];

  request_switch_top #(
    .CMD_DEPTH  (4),
    .DATA_DEPTH (8)
  ) dut (
    .i_clk          (i_clk),
    .i_rst_n        (i_rst_n),
    .i_scmd_valid   (i_scmd_valid),
    .i_scmd_type    (i_scmd_type),
    .i_scmd_id      (i_scmd_id),
    .i_scmd_addr    (i_scmd_addr),
    .i_scmd_len     (i_scmd_len),
    .o_scmd_accept  (o_scmd_accept),
    .i_sdata_valid  (i_sdata_valid),
    .i_sdata        (i_sdata),
    .i_sdata_last   (i_sdata_last),
    .o_sdata_accept (o_sdata_accept),
    .o_mcmd_valid   (o_mcmd_valid),
    .o_mcmd_type    (o_mcmd_type),
    .o_mcmd_id      (o_mcmd_id),
    .o_mcmd_addr    (o_mcmd_addr),
    .o_mcmd_len     (o_mcmd_len),
    .i_mcmd_accept  (i_mcmd_accept),
    .o_mdata_valid  (o_mdata_valid),
    .o_mdata        (o_mdata),
    .o_mdata_last   (o_mdata_last),
    .i_mdata_accept (i_mdata_accept)
  );

  initial begin
    i_clk = 1'b0;
    forever #20 i_clk = ~i_clk;
  end

  //////////////////////////////////////////////////
  // Helpers
  //////////////////////////////////////////////////

  task automatic check_value(input string name, input logic [31:0] want,
                             input logic [31:0] got, inout int errors);
    assert (got == want) else begin
      $display("ERROR %0t: %s expected %h got %h", $time, name, want, got);
      errors++;
    end
  endtask

  // Unwritten words keep a fill that no type value can match
  task automatic load_tests();
    for (int i = 0; i < MAX_TESTS * 6; i++) begin
      test_mem[i] = ~32'(i);
    end
    $readmemh("dv/request_switch_tests.txt", test_mem);
    num_tests = 0;
    while (num_tests < MAX_TESTS && test_mem[6*num_tests] != ~32'(6*num_tests)) begin
      num_tests++;
    end
  endtask

  // Commands queue by the mask column and data by the top address bits
  task automatic build_expected();
    int         b;
    int         t;
    int         max_beats;
    logic [3:0] rule;
    max_beats = 1;
    for (int m = 0; m < MASTERS; m++) begin
      cmd_tail[m]  = 0;
      data_tail[m] = 0;
    end
    for (int k = 0; k < num_tests; k++) begin
      b    = 6 * k;
      t    = int'(test_mem[b+2][15:14]);
      rule = (test_mem[b] == 32'd3) ? 4'hf : (4'b0001 << test_mem[b+2][15:14]);
      assert (rule == test_mem[b+5][3:0]) else begin
        $display("test %0d has a target mask that does not match its address", k);
        tb_errors++;
      end
      for (int m = 0; m < MASTERS; m++) begin
        if (test_mem[b+5][m]) begin
          exp_cmd[m][cmd_tail[m]] = {test_mem[b][1:0], test_mem[b+1][3:0],
                                     test_mem[b+2][15:0], test_mem[b+3][3:0]};
          cmd_tail[m]++;
        end
      end
      if (test_mem[b] == 32'd1 || test_mem[b] == 32'd2) begin
        for (int beat = 0; beat <= int'(test_mem[b+3]); beat++) begin
          exp_data[t][data_tail[t]] = {beat == int'(test_mem[b+3]),
                                       test_mem[b+4] + 32'(beat)};
          data_tail[t]++;
        end
        if (int'(test_mem[b+3]) + 1 > max_beats) begin
          max_beats = int'(test_mem[b+3]) + 1;
        end
      end
      for (int m = 0; m < MASTERS; m++) begin
        cmd_end[k][m]  = cmd_tail[m];
        data_end[k][m] = data_tail[m];
      end
    end
    limit_ns = num_tests * max_beats * 200;
  endtask

  task automatic send_commands();
    logic taken;
    for (int k = 0; k < num_tests; k++) begin
      i_scmd_valid = 1'b1;
      i_scmd_type  = corebus_switch_pkg::command_type'(test_mem[6*k][1:0]);
      i_scmd_id    = test_mem[6*k+1][3:0];
      i_scmd_addr  = test_mem[6*k+2][15:0];
      i_scmd_len   = test_mem[6*k+3][3:0];
      do begin
        taken = o_scmd_accept;
        @(negedge i_clk);
      end while (!taken);
      i_scmd_valid = 1'b0;
    end
  endtask

  task automatic send_data();
    logic taken;
    int   b;
    for (int k = 0; k < num_tests; k++) begin
      b = 6 * k;
      if (test_mem[b] == 32'd1 || test_mem[b] == 32'd2) begin
        for (int beat = 0; beat <= int'(test_mem[b+3]); beat++) begin
          i_sdata_valid = 1'b1;
          i_sdata       = test_mem[b+4] + 32'(beat);
          i_sdata_last  = (beat == int'(test_mem[b+3]));
          do begin
            taken = o_sdata_accept;
            @(negedge i_clk);
          end while (!taken);
          i_sdata_valid = 1'b0;
        end
      end
    end
  endtask

  function automatic logic test_done(input int k);
    logic done;
    done = 1'b1;
    for (int m = 0; m < MASTERS; m++) begin
      if (cmd_seen[m] < cmd_end[k][m] || data_seen[m] < data_end[k][m]) begin
        done = 1'b0;
      end
    end
    return done;
  endfunction

  task automatic report_tests();
    for (int k = 0; k < num_tests; k++) begin
      while (!test_done(k)) begin
        @(negedge i_clk);
      end
      $display("test %0d done: type %0d id %h addr %h at %0t", k, test_mem[6*k],
               test_mem[6*k+1][3:0], test_mem[6*k+2][15:0], $time);
    end
  endtask

  //////////////////////////////////////////////////
  // Master monitors
  //////////////////////////////////////////////////

  for (genvar m = 0; m < MASTERS; m++) begin : g_monitor
    int          seed = SEED + m;
    int          cmd_head = 0;
    int          data_head = 0;
    int          errors = 0;
    logic        cmd_acc = 1'b0;
    logic        data_acc = 1'b0;
    logic [25:0] want_cmd;
    logic [32:0] want_data;

    assign i_mcmd_accept[m]  = cmd_acc;
    assign i_mdata_accept[m] = data_acc;
    assign cmd_seen[m]       = cmd_head;
    assign data_seen[m]      = data_head;
    assign mon_errors[m]     = errors;

    // Accept picked here takes effect at the next rising edge
    always @(negedge i_clk) begin
      if (running) begin
        cmd_acc  = ($random(seed) & 3) != 0;
        data_acc = ($random(seed) & 3) != 0;
        if (o_mcmd_valid[m] && cmd_acc) begin
          assert (cmd_head < cmd_tail[m]) else begin
            $display("master %0d received a command nobody sent at %0t", m, $time);
            errors++;
          end
          if (cmd_head < cmd_tail[m]) begin
            want_cmd = exp_cmd[m][cmd_head];
            check_value($sformatf("o_mcmd_type[%0d]", m), 32'(want_cmd[25:24]),
                        32'(o_mcmd_type[m]), errors);
            check_value($sformatf("o_mcmd_id[%0d]", m), 32'(want_cmd[23:20]),
                        32'(o_mcmd_id[m]), errors);
            check_value($sformatf("o_mcmd_addr[%0d]", m), 32'(want_cmd[19:4]),
                        32'(o_mcmd_addr[m]), errors);
            check_value($sformatf("o_mcmd_len[%0d]", m), 32'(want_cmd[3:0]),
                        32'(o_mcmd_len[m]), errors);
            cmd_head++;
          end
        end
        if (o_mdata_valid[m] && data_acc) begin
          assert (data_head < data_tail[m]) else begin
            $display("master %0d received a data beat nobody sent at %0t", m, $time);
            errors++;
          end
          if (data_head < data_tail[m]) begin
            want_data = exp_data[m][data_head];
            check_value($sformatf("o_mdata[%0d]", m), want_data[31:0], o_mdata[m], errors);
            check_value($sformatf("o_mdata_last[%0d]", m), 32'(want_data[32]),
                        32'(o_mdata_last[m]), errors);
            data_head++;
          end
        end
      end
    end
  end

  //////////////////////////////////////////////////
  // Main sequence and watchdog
  //////////////////////////////////////////////////

  initial begin
    int total;
    int arrivals;
    i_rst_n       = 1'b0;
    i_scmd_valid  = 1'b0;
    i_scmd_type   = corebus_switch_pkg::CMD_READ;
    i_scmd_id     = '0;
    i_scmd_addr   = '0;
    i_scmd_len    = '0;
    i_sdata_valid = 1'b0;
    i_sdata       = '0;
    i_sdata_last  = 1'b0;
    load_tests();
    assert (num_tests > 0) else begin
      $display("no tests could be read from the tests file");
      tb_errors++;
    end
    build_expected();
    repeat (2) @(negedge i_clk);
    i_rst_n = 1'b1;
    @(negedge i_clk);
    check_value("o_mcmd_valid", 32'h0, 32'(o_mcmd_valid), tb_errors);
    check_value("o_mdata_valid", 32'h0, 32'(o_mdata_valid), tb_errors);
    check_value("o_scmd_accept", 32'h1, 32'(o_scmd_accept), tb_errors);
    check_value("o_sdata_accept", 32'h1, 32'(o_sdata_accept), tb_errors);
    running = 1'b1;
    fork
      send_commands();
      send_data();
      report_tests();
    join
    // A few idle cycles to catch late duplicates
    repeat (10) @(negedge i_clk);
    total    = tb_errors;
    arrivals = 0;
    for (int m = 0; m < MASTERS; m++) begin
      total    = total + mon_errors[m];
      arrivals = arrivals + cmd_seen[m] + data_seen[m];
    end
    $display("%0d tests, %0d arrivals, %0d errors", num_tests, arrivals, total);
    if (total == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

  initial begin
    wait (limit_ns > 0);
    #(limit_ns);
    $display("timeout after %0d ns, not every expected arrival was seen", limit_ns);
    $display("FAIL: see errors above");
    $finish;
  end

endmodule

//--- list.f
verilog/corebus_switch_pkg.sv
verilog/request_fifo.sv
verilog/switch_control.sv
verilog/request_switch_top.sv
dv/request_switch_tb.sv

//--- Makefile
LOG = sim.log

.PHONY: all run lint clean

all: run

obj_dir/Vrequest_switch_tb: list.f verilog/*.sv dv/request_switch_tb.sv
	verilator --binary --timing --assert -j 0 --top-module request_switch_tb -f list.f

run: obj_dir/Vrequest_switch_tb
	./obj_dir/Vrequest_switch_tb | tee $(LOG)
	@if grep -q "FAIL: see errors above" $(LOG) || ! grep -q "PASS: all tests" $(LOG); then \
		echo "simulation failed"; \
		exit 1; \
	fi

lint:
	verilator --lint-only --timing --assert --top-module request_switch_top -f list.f

clean:
	rm -rf obj_dir $(LOG)

//--- dv/request_switch_tests.txt
// Columns: command type, id, address, burst length, first data word, target mask
// Types 0 read, 1 posted write, 2 non-posted write, 3 broadcast
0 1 0010 0 00000000 1
0 2 4020 0 00000000 2
0 3 8030 5 00000000 4
0 4 c040 0 00000000 8
1 5 0100 3 10000000 1
2 6 5200 7 20000000 2
3 7 1234 0 00000000 f
1 8 a300 0 30000000 4
1 9 f400 5 40000000 8
0 a 7000 2 00000000 2
3 b 0000 0 00000000 f
2 c 2500 2 50000000 1
1 d 6600 1 60000000 2
3 c ffff 0 00000000 f
1 e b700 7 70000000 4
0 f e800 0 00000000 8
2 0 3900 4 80000000 1
1 1 ca00 6 90000000 8
